/* Makefile */
VERILATOR ?= verilator
TOP       ?= exec_core_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* design/alu_exec.sv */
`default_nettype none
`timescale 1ns/100ps

module alu_exec (
	input  logic             clk,
	input  logic             flush,
	input  cpu_pkg::id_exe_t stage,
	output logic             result_valid,
	output cpu_pkg::wb_t     result
);

	import cpu_pkg::*;

	word_t value;

	////////////////////////////////////////
	// ALU, all modulo 2**16
	////////////////////////////////////////

	always_comb begin
		case (stage.ctrl.alu_op)
			ALU_ADD:  value = stage.op1 + stage.op2;
			ALU_SUB:  value = stage.op1 - stage.op2;
			ALU_AND:  value = stage.op1 & stage.op2;
			ALU_OR:   value = stage.op1 | stage.op2;
			ALU_SLL:  value = stage.op1 << stage.op2[3:0]; // Shift of 1 to 8
			ALU_PASS: value = stage.op1;
			default:  value = '0;
		endcase
	end

	always_ff @(posedge clk or posedge flush) begin
		if (flush) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= stage.ctrl.reg_write;
		end
	end

	// Write-back record, qualified by result_valid
	always_ff @(posedge clk) begin
		result.reg_addr <= stage.ctrl.reg_addr;
		result.value    <= value;
		result.pc       <= stage.pc;
	end

	// ID/EXE was cleared too, so the first edge out of flush carries nothing
	a_quiet_after_flush: assert property (
		@(posedge clk) $fell(flush) |=> !result_valid
	);

endmodule

`default_nettype wire

/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	////////////////////////////////////////
	// Basic widths
	////////////////////////////////////////

	typedef logic [15:0] word_t;     // Data, instruction and pc
	typedef logic [2:0]  reg_addr_t; // One of eight general registers

	////////////////////////////////////////
	// Encodings
	////////////////////////////////////////

	// Major opcodes, bits 15:11
	localparam logic [4:0] OP_ADDIU = 5'b01001;
	localparam logic [4:0] OP_RRR   = 5'b11100; // ADDU, SUBU
	localparam logic [4:0] OP_RR    = 5'b11101; // AND, OR
	localparam logic [4:0] OP_LI    = 5'b01101;
	localparam logic [4:0] OP_SHIFT = 5'b00110; // SLL
	localparam logic [4:0] OP_MOVE  = 5'b01111;

	// Function fields in the low bits
	localparam logic [1:0] FN_ADDU = 2'b01;
	localparam logic [1:0] FN_SUBU = 2'b11;
	localparam logic [4:0] FN_AND  = 5'b01100;
	localparam logic [4:0] FN_OR   = 5'b01101;
	localparam logic [1:0] FN_SLL  = 2'b00;
	localparam logic [4:0] FN_MOVE = 5'b00000;

	localparam word_t NOP_WORD = 16'h0800;

	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_AND  = 3'd2,
		ALU_OR   = 3'd3,
		ALU_SLL  = 3'd4,
		ALU_PASS = 3'd5  // Forwards op1
	} alu_op_e;

	////////////////////////////////////////
	// Pipeline records
	////////////////////////////////////////

	typedef struct packed {
		logic      reg_write;
		alu_op_e   alu_op;
		reg_addr_t reg_addr;   // Destination
	} id_ctrl_t;

	typedef struct packed {
		id_ctrl_t ctrl;
		word_t    op1;
		word_t    op2;
		word_t    pc;
	} id_exe_t;

	typedef struct packed {
		reg_addr_t reg_addr;
		word_t     value;
		word_t     pc;
	} wb_t;

endpackage

`default_nettype wire

/* design/exec_core.sv */
`default_nettype none
`timescale 1ns/100ps

module exec_core (
	input  logic           clk,
	input  logic           flush,
	input  logic           instr_valid,
	input  cpu_pkg::word_t instr,
	input  cpu_pkg::word_t pc,
	output logic           result_valid,
	output cpu_pkg::wb_t   result
);

	import cpu_pkg::*;

	reg_addr_t rx_addr;
	reg_addr_t ry_addr;
	word_t     rx_value;
	word_t     ry_value;
	id_ctrl_t  ctrl;
	id_exe_t   stage;

	////////////////////////////////////////
	// ID stage
	////////////////////////////////////////

	instr_decode u_decode (
		.instr       (instr),
		.instr_valid (instr_valid),
		.rx_addr     (rx_addr),
		.ry_addr     (ry_addr),
		.ctrl        (ctrl)
	);

	reg_file u_regs (
		.clk      (clk),
		.flush    (flush),
		.rx_addr  (rx_addr),
		.ry_addr  (ry_addr),
		.rx_value (rx_value),
		.ry_value (ry_value),
		.wb_valid (result_valid),  // Write-back straight from execute
		.wb       (result)
	);

	////////////////////////////////////////
	// ID/EXE and EXE stages
	////////////////////////////////////////

	id_exe u_id_exe (
		.clk      (clk),
		.flush    (flush),
		.instr    (instr),
		.pc       (pc),
		.ctrl     (ctrl),
		.rx_value (rx_value),
		.ry_value (ry_value),
		.stage    (stage)
	);

	alu_exec u_exec (
		.clk          (clk),
		.flush        (flush),
		.stage        (stage),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

`default_nettype wire

/* design/id_exe.sv */
`default_nettype none
`timescale 1ns/100ps

module id_exe (
	input  logic              clk,
	input  logic              flush,
	input  cpu_pkg::word_t    instr,
	input  cpu_pkg::word_t    pc,
	input  cpu_pkg::id_ctrl_t ctrl,
	input  cpu_pkg::word_t    rx_value,
	input  cpu_pkg::word_t    ry_value,
	output cpu_pkg::id_exe_t  stage
);

	import cpu_pkg::*;

	word_t op1;
	word_t op2;
	word_t imm_sext;
	word_t imm_zext;
	word_t shamt;

	assign imm_sext = {{8{instr[7]}}, instr[7:0]};
	assign imm_zext = {8'h00, instr[7:0]};
	// SLL field of zero encodes a shift by eight
	assign shamt    = (instr[4:2] == 3'd0) ? 16'd8 : {13'd0, instr[4:2]};

	////////////////////////////////////////
	// Operand select by opcode
	////////////////////////////////////////

	always_comb begin
		op1 = '0;  // NOP and unknown words
		op2 = '0;
		case (instr[15:11])
			OP_ADDIU: begin
				op1 = rx_value;
				op2 = imm_sext;
			end
			OP_RRR, OP_RR: begin
				op1 = rx_value;  // ADDU, SUBU, AND, OR
				op2 = ry_value;
			end
			OP_LI: begin
				op1 = imm_zext;
			end
			OP_SHIFT: begin
				if (instr[1:0] == FN_SLL) begin
					op1 = ry_value;
					op2 = shamt;
				end
			end
			OP_MOVE: begin
				if (instr[4:0] == FN_MOVE) begin
					op1 = ry_value;
				end
			end
			default: begin
				op1 = '0;
				op2 = '0;
			end
		endcase
	end

	always_ff @(posedge clk or posedge flush) begin
		if (flush) begin
			stage <= '0;  // Drops the instruction in flight
		end else begin
			stage.ctrl <= ctrl;
			stage.op1  <= op1;
			stage.op2  <= op2;
			stage.pc   <= pc;
		end
	end

	// Decode must never hand a write with a garbage operation
	a_alu_op_known: assert property (
		@(posedge clk) disable iff (flush)
		stage.ctrl.reg_write |-> !$isunknown(stage.ctrl.alu_op)
	);

endmodule

`default_nettype wire

/* design/instr_decode.sv */
`default_nettype none
`timescale 1ns/100ps

module instr_decode (
	input  cpu_pkg::word_t    instr,
	input  logic              instr_valid,
	output cpu_pkg::reg_addr_t rx_addr,
	output cpu_pkg::reg_addr_t ry_addr,
	output cpu_pkg::id_ctrl_t ctrl
);

	import cpu_pkg::*;

	logic [4:0] opcode;
	reg_addr_t  rx;
	reg_addr_t  ry;
	reg_addr_t  rz;

	logic       hit;  // Kept encoding that writes a register
	alu_op_e    op;
	reg_addr_t  dest;

	assign opcode = instr[15:11];
	assign rx     = instr[10:8];
	assign ry     = instr[7:5];
	assign rz     = instr[4:2];

	// Register file is read for every word, used or not
	assign rx_addr = rx;
	assign ry_addr = ry;

	////////////////////////////////////////
	// Encoding match
	////////////////////////////////////////

	always_comb begin
		hit  = 1'b0;
		op   = ALU_ADD;
		dest = rx;   // Most instructions write rx
		case (opcode)
			OP_ADDIU: begin
				hit = 1'b1;
			end
			OP_RRR: begin
				dest = rz;
				if (instr[1:0] == FN_ADDU) begin
					hit = 1'b1;
				end else if (instr[1:0] == FN_SUBU) begin
					hit = 1'b1;
					op  = ALU_SUB;
				end
			end
			OP_RR: begin
				if (instr[4:0] == FN_AND) begin
					hit = 1'b1;
					op  = ALU_AND;
				end else if (instr[4:0] == FN_OR) begin
					hit = 1'b1;
					op  = ALU_OR;
				end
			end
			OP_LI: begin
				hit = 1'b1;
				op  = ALU_PASS;  // Immediate already in op1
			end
			OP_SHIFT: begin
				hit = (instr[1:0] == FN_SLL);
				op  = ALU_SLL;
			end
			OP_MOVE: begin
				hit = (instr[4:0] == FN_MOVE);
				op  = ALU_PASS;
			end
			default: hit = 1'b0;
		endcase
	end

	// Unstrobed, NOP or unknown words give zero control
	always_comb begin
		ctrl = '0;
		if (instr_valid && instr != NOP_WORD && hit) begin
			ctrl.reg_write = 1'b1;
			ctrl.alu_op    = op;
			ctrl.reg_addr  = dest;
		end
	end

endmodule

`default_nettype wire

/* design/reg_file.sv */
`default_nettype none
`timescale 1ns/100ps

module reg_file (
	input  logic               clk,
	input  logic               flush,
	input  cpu_pkg::reg_addr_t rx_addr,
	input  cpu_pkg::reg_addr_t ry_addr,
	output cpu_pkg::word_t     rx_value,
	output cpu_pkg::word_t     ry_value,
	input  logic               wb_valid,
	input  cpu_pkg::wb_t       wb
);

	import cpu_pkg::*;

	word_t regs [8];

	// Write lands on the edge, readers see it next cycle
	always_ff @(posedge clk or posedge flush) begin
		if (flush) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_valid) begin
			regs[wb.reg_addr] <= wb.value;
		end
	end

	assign rx_value = regs[rx_addr]; // No bypass of same-cycle write
	assign ry_value = regs[ry_addr];

	// Write strobe from execute must be clean once out of flush
	a_wb_valid_known: assert property (
		@(posedge clk) disable iff (flush) !$isunknown(wb_valid)
	);

endmodule

`default_nettype wire

/* list.f */
design/cpu_pkg.sv
design/instr_decode.sv
design/reg_file.sv
design/id_exe.sv
design/alu_exec.sv
design/exec_core.sv
tb/exec_core_tb.sv

/* tb/exec_core_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module exec_core_tb;

	import cpu_pkg::*;

	localparam int MAX_CYCLES = 2000;  // Several times the full test sequence

	logic   clk;
	logic   flush;
	logic   instr_valid;
	word_t  instr;
	word_t  pc;
	logic   result_valid;
	wb_t    result;

	word_t  model [8];   // Reference register contents
	logic   pipe_v [2];  // Expected strobes, slot 1 is due this cycle
	wb_t    pipe_r [2];
	word_t  next_pc;
	integer seed;
	int     cycle_count = 0;

	exec_core dut0 (
		.clk          (clk),
		.flush        (flush),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.pc           (pc),
		.result_valid (result_valid),
		.result       (result)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Result: FAILED");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	function automatic word_t rand_word();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	function automatic word_t imm_word(input logic [4:0] op, input reg_addr_t rx,
			input logic [7:0] imm);
		return {op, rx, imm};
	endfunction

	function automatic word_t reg_word(input logic [4:0] op, input reg_addr_t rx,
			input reg_addr_t ry, input logic [4:0] low);
		return {op, rx, ry, low};
	endfunction

	// Expected write-back from the instruction rules and the model registers
	task automatic model_result(input word_t w, output logic ev, output wb_t er);
		reg_addr_t rx;
		reg_addr_t ry;
		int        amount;
		rx          = w[10:8];
		ry          = w[7:5];
		amount      = (w[4:2] == 3'd0) ? 8 : int'(w[4:2]);
		ev          = 1'b1;
		er          = '0;
		er.reg_addr = rx;
		case (w[15:11])
			OP_ADDIU: er.value = model[rx] + {{8{w[7]}}, w[7:0]};
			OP_LI:    er.value = {8'h00, w[7:0]};
			OP_RRR: begin
				er.reg_addr = w[4:2];  // rz
				if (w[1:0] == 2'b01)
					er.value = model[rx] + model[ry];
				else if (w[1:0] == 2'b11)
					er.value = model[rx] - model[ry];
				else
					ev = 1'b0;
			end
			OP_RR: begin
				if (w[4:0] == 5'b01100)
					er.value = model[rx] & model[ry];
				else if (w[4:0] == 5'b01101)
					er.value = model[rx] | model[ry];
				else
					ev = 1'b0;
			end
			OP_SHIFT: begin
				if (w[1:0] == 2'b00)
					er.value = model[ry] << amount;
				else
					ev = 1'b0;
			end
			OP_MOVE: begin
				if (w[4:0] == 5'b00000)
					er.value = model[ry];
				else
					ev = 1'b0;
			end
			default: ev = 1'b0;  // NOP and unknown words
		endcase
	endtask

	// One clock: check the due result, then drive the next input
	task automatic step(input logic v, input word_t w, input word_t p);
		logic ev;
		wb_t  er;
		logic wr_v;
		wb_t  wr_r;
		@(posedge clk);
		#1;
		assert (result_valid === pipe_v[1]) else
			stop_on_error($sformatf("Error: result_valid = %h, expected %h",
				result_valid, pipe_v[1]));
		if (pipe_v[1]) begin
			assert (result.reg_addr === pipe_r[1].reg_addr) else
				stop_on_error($sformatf("Error: result.reg_addr = %h, expected %h",
					result.reg_addr, pipe_r[1].reg_addr));
			assert (result.value === pipe_r[1].value) else
				stop_on_error($sformatf("Error: result.value = %h, expected %h",
					result.value, pipe_r[1].value));
			assert (result.pc === pipe_r[1].pc) else
				stop_on_error($sformatf("Error: result.pc = %h, expected %h",
					result.pc, pipe_r[1].pc));
		end
		wr_v = pipe_v[1];
		wr_r = pipe_r[1];
		#1;
		instr_valid = v;
		instr       = w;
		pc          = p;
		ev          = 1'b0;
		er          = '0;
		if (v && !flush)
			model_result(w, ev, er);
		er.pc     = p;
		pipe_v[1] = pipe_v[0];
		pipe_r[1] = pipe_r[0];
		pipe_v[0] = ev;
		pipe_r[0] = er;
		if (wr_v)
			model[wr_r.reg_addr] = wr_r.value;  // Seen by reads from the next strobe on
	endtask

	task automatic issue(input word_t w);
		step(1'b1, w, next_pc);
		next_pc = next_pc + 16'd1;
	endtask

	task automatic idle(input int n);
		repeat (n) step(1'b0, NOP_WORD, 16'h0000);
	endtask

	task automatic flush_pipeline(input int n);
		flush = 1'b1;
		for (int i = 0; i < 8; i++)
			model[i] = '0;
		pipe_v[0] = 1'b0;  // In-flight work is dropped
		pipe_v[1] = 1'b0;
		idle(n);
		flush = 1'b0;
	endtask

	// Builds a 16-bit value through LI, SLL and OR, r7 is scratch
	task automatic load_reg(input reg_addr_t r, input word_t value);
		issue(imm_word(OP_LI, r, value[15:8]));
		issue(imm_word(OP_LI, 3'd7, value[7:0]));
		idle(1);
		issue(reg_word(OP_SHIFT, r, r, {3'd0, FN_SLL}));
		idle(2);
		issue(reg_word(OP_RR, r, 3'd7, FN_OR));
		idle(2);
	endtask

	// Swapped pairs read both registers before either write lands
	task automatic read_all_zero();
		for (int i = 0; i < 8; i += 2) begin
			issue(reg_word(OP_MOVE, reg_addr_t'(i + 1), reg_addr_t'(i), FN_MOVE));
			issue(reg_word(OP_MOVE, reg_addr_t'(i), reg_addr_t'(i + 1), FN_MOVE));
			idle(2);
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic after_flush_test();
		repeat (3) issue(NOP_WORD);  // Strobed but no write
		idle(2);
		read_all_zero();
	endtask

	task automatic li_addiu_test();
		word_t r;
		for (int i = 0; i < 8; i++) begin
			r = rand_word();
			issue(imm_word(OP_LI, reg_addr_t'(i), r[7:0]));
		end
		idle(2);
		for (int i = 0; i < 8; i++) begin
			r = rand_word();
			if (i % 2 == 0)
				issue(imm_word(OP_ADDIU, reg_addr_t'(i), r[7:0] | 8'h80));
			else
				issue(imm_word(OP_ADDIU, reg_addr_t'(i), r[7:0] & 8'h7f));
		end
		idle(2);
		load_reg(3'd0, 16'hfff0);
		issue(imm_word(OP_ADDIU, 3'd0, 8'h20));  // Carries out of bit 15
		idle(2);
	endtask

	task automatic reg_ops_test();
		word_t r;
		for (int k = 0; k < 7; k++)
			load_reg(reg_addr_t'(k), rand_word());
		for (int n = 0; n < 12; n++) begin
			r = rand_word();
			case (n % 4)
				0: issue(reg_word(OP_RRR, r[2:0], r[5:3], {r[8:6], FN_ADDU}));
				1: issue(reg_word(OP_RRR, r[2:0], r[5:3], {r[8:6], FN_SUBU}));
				2: issue(reg_word(OP_RR, r[2:0], r[5:3], FN_AND));
				default: issue(reg_word(OP_RR, r[2:0], r[5:3], FN_OR));
			endcase
			idle(2);
		end
	endtask

	task automatic shift_move_test();
		load_reg(3'd1, rand_word());
		for (int s = 0; s < 8; s++)
			issue(reg_word(OP_SHIFT, 3'd2, 3'd1, {3'(s), FN_SLL}));  // imm3 of 0 is 8
		idle(2);
		for (int i = 0; i < 8; i++) begin
			issue(reg_word(OP_MOVE, reg_addr_t'((i + 3) % 8), reg_addr_t'(i), FN_MOVE));
			idle(2);
		end
	endtask

	task automatic back_to_back_test();
		word_t r;
		for (int i = 0; i < 8; i++) begin
			r = rand_word();
			issue(imm_word(OP_LI, reg_addr_t'(i), r[7:0]));
		end
		idle(2);
		issue(reg_word(OP_RRR, 3'd0, 3'd1, {3'd6, FN_ADDU}));
		issue(reg_word(OP_RRR, 3'd2, 3'd3, {3'd7, FN_SUBU}));
		issue(reg_word(OP_RR, 3'd4, 3'd5, FN_AND));
		issue(reg_word(OP_RR, 3'd0, 3'd1, FN_OR));
		issue(imm_word(OP_ADDIU, 3'd6, 8'h05));
		issue(NOP_WORD);
		issue(NOP_WORD);
		issue(imm_word(OP_ADDIU, 3'd6, 8'h05));  // Reads the first ADDIU result
		idle(2);
	endtask

	task automatic flush_in_flight_test();
		issue(imm_word(OP_LI, 3'd1, 8'h5a));
		issue(imm_word(OP_LI, 3'd2, 8'ha5));
		flush_pipeline(3);
		idle(2);
		read_all_zero();
	endtask

	initial begin
		seed        = 32'hcc84108b;
		next_pc     = 16'h0100;
		flush       = 1'b1;
		instr_valid = 1'b0;
		instr       = NOP_WORD;
		pc          = 16'h0000;
		flush_pipeline(16);
		after_flush_test();
		li_addiu_test();
		reg_ops_test();
		shift_move_test();
		back_to_back_test();
		flush_in_flight_test();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire
